// ==== all.f ====
snd_bus_pkg.sv
snd_audio_pkg.sv
snd_cen_gen.sv
snd_addr_decode.sv
snd_ctrl_regs.sv
snd_work_ram.sv
snd_rd_mux.sv
snd_mixer.sv
snd_board.sv
tb_snd_board.sv

// ==== run.sh ====
#!/bin/sh
# build and run the sound board testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_snd_board -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
if ! grep -q "TEST PASSED" sim.log; then
    echo "no result line found in sim.log"
    exit 1
fi
exit 0

// ==== snd_addr_decode.sv ====
`timescale 1ns/1ps

module snd_addr_decode (
    input  logic                     clk,
    input  logic                     rst,
    input  snd_bus_pkg::snd_cpu_bus_t bus,
    input  logic                     bank,
    output snd_bus_pkg::snd_cs_t     cs,
    output logic [15:0]              rom_addr
);

    logic       io_sel;
    logic [2:0] io_ofs;
    logic       rom_sel;
    logic [5:0] io_sels;  // the six decoded I/O registers

    assign io_sel = bus.mreq && bus.addr[15:12] == snd_bus_pkg::IO_PAGE;
    assign io_ofs = bus.addr[3:1];

    // fixed ROM below 8000, banked window above
    assign rom_sel = bus.mreq && bus.rd &&
                     (!bus.addr[15] || bus.addr[15:14] == snd_bus_pkg::ROM_BANK_WIN);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cs       <= '0;
            rom_addr <= '0;
        end else begin
            cs.rom    <= rom_sel;
            cs.ram    <= bus.mreq && bus.addr[15:12] == snd_bus_pkg::RAM_PAGE;
            cs.io     <= io_sel;
            cs.fm     <= io_sel && io_ofs == snd_bus_pkg::OFS_FM;
            cs.pcm    <= io_sel && io_ofs == snd_bus_pkg::OFS_PCM;
            cs.bank   <= io_sel && io_ofs == snd_bus_pkg::OFS_BANK;
            cs.rate   <= io_sel && io_ofs == snd_bus_pkg::OFS_RATE;
            cs.latch0 <= io_sel && io_ofs == snd_bus_pkg::OFS_LATCH0;
            cs.latch1 <= io_sel && io_ofs == snd_bus_pkg::OFS_LATCH1;
            if (bus.addr[15])
                rom_addr <= {1'b1, bank, bus.addr[13:0]};  // 16K page picked by bank
            else
                rom_addr <= {1'b0, bus.addr[14:0]};
        end
    end

    assign io_sels = {cs.fm, cs.pcm, cs.bank, cs.rate, cs.latch0, cs.latch1};

    // the read mux and write strobes rely on a single register hit
    a_io_onehot: assert property (
        @(posedge clk) disable iff (rst) $onehot0(io_sels)
    ) else $error("snd_addr_decode: more than one I/O select");

endmodule

// ==== snd_audio_pkg.sv ====
package snd_audio_pkg;

    // one audio sample, two's complement
    typedef logic signed [15:0] sample_t;

    // channel gain, unsigned 4.4 fixed point
    // 8'h10 is unity, 8'h08 is one half
    typedef logic [7:0] gain_t;

    // FM is louder than the ADPCM voice at the source
    localparam gain_t FM_GAIN  = 8'h08;
    localparam gain_t PCM_GAIN = 8'h10;

    // widths used inside the mixer datapath
    localparam int SAMPLE_W = 16;
    localparam int GAIN_W   = 8;
    localparam int GAIN_FRAC = 4;

endpackage

// ==== snd_board.sv ====
`timescale 1ns/1ps

module snd_board #(
    parameter logic [9:0] CEN_N  = 10'd1,
    parameter logic [9:0] CEN_M  = 10'd8,
    parameter int         RAM_AW = 11
) (
    input  logic                      clk,
    input  logic                      rst,

    // sound CPU bus
    input  snd_bus_pkg::snd_cpu_bus_t bus,
    output logic [7:0]                din,
    output logic                      cpu_cen,

    // from the main CPU
    input  logic [7:0]                snd_latch0,
    input  logic [7:0]                snd_latch1,
    input  logic                      fm_en,
    input  logic                      pcm_en,

    // program ROM
    output logic [15:0]               rom_addr,
    output logic                      rom_cs,
    input  logic [7:0]                rom_data,
    input  logic                      rom_ok,
    output logic                      rom_ready,

    // FM and ADPCM chips
    output logic                      fm_wr,
    output logic                      fm_a0,
    input  logic [7:0]                fm_dout,
    output logic                      pcm_wr,
    output logic                      pcm_rate_sel,
    input  logic [7:0]                pcm_dout,

    // sample paths
    input  snd_audio_pkg::sample_t    fm_left,
    input  snd_audio_pkg::sample_t    fm_right,
    input  snd_audio_pkg::sample_t    pcm_snd,
    output snd_audio_pkg::sample_t    left,
    output snd_audio_pkg::sample_t    right
);

    snd_bus_pkg::snd_cs_t cs;
    logic                 bank;
    logic                 ram_we;
    logic [7:0]           ram_q;
    snd_audio_pkg::gain_t fm_gain, pcm_gain;

    snd_cen_gen #(
        .CEN_N (CEN_N),
        .CEN_M (CEN_M)
    ) i_cen_gen (
        .clk (clk),
        .rst (rst),
        .cen (cpu_cen)
    );

    snd_addr_decode i_addr_decode (
        .clk      (clk),
        .rst      (rst),
        .bus      (bus),
        .bank     (bank),
        .cs       (cs),
        .rom_addr (rom_addr)
    );

    snd_ctrl_regs i_ctrl_regs (
        .clk          (clk),
        .rst          (rst),
        .bus          (bus),
        .cs           (cs),
        .cpu_cen      (cpu_cen),
        .bank         (bank),
        .pcm_rate_sel (pcm_rate_sel)
    );

    assign rom_cs = cs.rom;
    assign ram_we = cs.ram && bus.wr;

    // chip write levels, sampled by the chips on their own enables
    assign fm_wr  = cs.fm && bus.wr;
    assign fm_a0  = bus.addr[0];        // register / data port
    assign pcm_wr = cs.pcm && bus.wr;

    snd_work_ram #(
        .RAM_AW (RAM_AW)
    ) i_work_ram (
        .clk  (clk),
        .addr (bus.addr[RAM_AW-1:0]),
        .din  (bus.dout),
        .we   (ram_we),
        .q    (ram_q)
    );

    snd_rd_mux i_rd_mux (
        .clk       (clk),
        .rst       (rst),
        .cs        (cs),
        .latch0    (snd_latch0),
        .latch1    (snd_latch1),
        .fm_dout   (fm_dout),
        .pcm_dout  (pcm_dout),
        .ram_q     (ram_q),
        .rom_data  (rom_data),
        .rom_ok    (rom_ok),
        .din       (din),
        .rom_ready (rom_ready)
    );

    // channel mute by zero gain
    assign fm_gain  = fm_en  ? snd_audio_pkg::FM_GAIN  : '0;
    assign pcm_gain = pcm_en ? snd_audio_pkg::PCM_GAIN : '0;

    snd_mixer i_mix_left (
        .clk   (clk),
        .rst   (rst),
        .ch0   (fm_left),
        .ch1   (pcm_snd),
        .gain0 (fm_gain),
        .gain1 (pcm_gain),
        .mixed (left)
    );

    snd_mixer i_mix_right (
        .clk   (clk),
        .rst   (rst),
        .ch0   (fm_right),
        .ch1   (pcm_snd),     // mono ADPCM on both sides
        .gain0 (fm_gain),
        .gain1 (pcm_gain),
        .mixed (right)
    );

endmodule

// ==== snd_bus_pkg.sv ====
package snd_bus_pkg;

    // bus as seen from the sound CPU, strobes active high
    typedef struct packed {
        logic [15:0] addr;
        logic        mreq;  // memory request
        logic        rd;
        logic        wr;
        logic [7:0]  dout;  // write data from the CPU
    } snd_cpu_bus_t;

    // registered chip selects, one per decoded region
    typedef struct packed {
        logic rom;
        logic ram;
        logic fm;
        logic pcm;
        logic bank;
        logic rate;
        logic latch0;
        logic latch1;
        logic io;     // whole F page
    } snd_cs_t;

    // top nibble of the address
    localparam logic [3:0] RAM_PAGE = 4'hd;
    localparam logic [3:0] IO_PAGE  = 4'hf;

    // banked ROM window 8000-BFFF
    localparam logic [1:0] ROM_BANK_WIN = 2'b10;

    // register offsets inside the I/O page, address bits 3:1
    localparam logic [2:0] OFS_FM     = 3'd0;
    localparam logic [2:0] OFS_PCM    = 3'd1;
    localparam logic [2:0] OFS_BANK   = 3'd2;
    localparam logic [2:0] OFS_RATE   = 3'd3;
    localparam logic [2:0] OFS_LATCH0 = 3'd4;
    localparam logic [2:0] OFS_LATCH1 = 3'd5;

    localparam logic [7:0] RD_IDLE = 8'hff;  // unmapped read value

endpackage

// ==== snd_cen_gen.sv ====
`timescale 1ns/1ps

module snd_cen_gen #(
    parameter logic [9:0] CEN_N = 10'd1,
    parameter logic [9:0] CEN_M = 10'd8
) (
    input  logic clk,
    input  logic rst,
    output logic cen
);

    logic [9:0]  acc;        // running remainder, always below CEN_M
    logic [10:0] acc_sum;
    logic [10:0] acc_wrap;

    assign acc_sum  = {1'b0, acc} + {1'b0, CEN_N};
    assign acc_wrap = acc_sum - {1'b0, CEN_M};

    // n over m: add n each clock, pulse when the sum reaches m
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acc <= '0;
            cen <= 1'b0;
        end else if (acc_sum >= {1'b0, CEN_M}) begin
            acc <= acc_wrap[9:0];
            cen <= 1'b1;
        end else begin
            acc <= acc_sum[9:0];
            cen <= 1'b0;
        end
    end

    // ratio above one cannot be produced by a single pulse per clock
    a_ratio_ok: assert property (
        @(posedge clk) disable iff (rst) CEN_N <= CEN_M
    ) else $error("snd_cen_gen: CEN_N larger than CEN_M");

    // remainder must stay inside the modulus or pulses get lost
    a_acc_range: assert property (
        @(posedge clk) disable iff (rst) acc < CEN_M
    ) else $error("snd_cen_gen: accumulator out of range");

endmodule

// ==== snd_ctrl_regs.sv ====
`timescale 1ns/1ps

module snd_ctrl_regs (
    input  logic                      clk,
    input  logic                      rst,
    input  snd_bus_pkg::snd_cpu_bus_t bus,
    input  snd_bus_pkg::snd_cs_t      cs,
    input  logic                      cpu_cen,
    output logic                      bank,
    output logic                      pcm_rate_sel
);

    logic wr_en;

    // writes land only on the CPU clock enable, like the real bus
    assign wr_en = bus.wr && cpu_cen;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bank         <= 1'b0;
            pcm_rate_sel <= 1'b0;
        end else if (wr_en) begin
            if (cs.bank)
                bank <= bus.dout[0];          // upper ROM page
            if (cs.rate)
                pcm_rate_sel <= bus.dout[0];  // ADPCM sample rate pin
        end
    end

endmodule

// ==== snd_mixer.sv ====
`timescale 1ns/1ps

module snd_mixer (
    input  logic                   clk,
    input  logic                   rst,
    input  snd_audio_pkg::sample_t ch0,
    input  snd_audio_pkg::sample_t ch1,
    input  snd_audio_pkg::gain_t   gain0,
    input  snd_audio_pkg::gain_t   gain1,
    output snd_audio_pkg::sample_t mixed
);

    localparam int PROD_W = snd_audio_pkg::SAMPLE_W + snd_audio_pkg::GAIN_W + 1;
    localparam int SUM_W  = PROD_W + 1;
    localparam int SCL_W  = SUM_W - snd_audio_pkg::GAIN_FRAC;

    localparam logic signed [SCL_W-1:0] POS_MAX = 32767;
    localparam logic signed [SCL_W-1:0] NEG_MIN = -32768;

    logic signed [PROD_W-1:0] prod0, prod1;
    logic signed [SUM_W-1:0]  sum;
    logic signed [SCL_W-1:0]  scaled;
    snd_audio_pkg::sample_t   clipped;

    // gains are unsigned, so widen with a zero sign bit
    assign prod0 = ch0 * $signed({1'b0, gain0});
    assign prod1 = ch1 * $signed({1'b0, gain1});
    assign sum   = prod0 + prod1;

    // drop the 4.4 fraction
    assign scaled = sum[SUM_W-1:snd_audio_pkg::GAIN_FRAC];

    always_comb begin
        if (scaled > POS_MAX)
            clipped = 16'sh7fff;
        else if (scaled < NEG_MIN)
            clipped = 16'sh8000;
        else
            clipped = scaled[15:0];
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            mixed <= '0;
        else
            mixed <= clipped;
    end

    // both channels muted gives silence on the next clock
    a_mute: assert property (
        @(posedge clk) disable iff (rst) (gain0 == '0 && gain1 == '0) |=> mixed == '0
    ) else $error("snd_mixer: muted output not zero");

endmodule

// ==== snd_rd_mux.sv ====
`timescale 1ns/1ps

module snd_rd_mux (
    input  logic                 clk,
    input  logic                 rst,
    input  snd_bus_pkg::snd_cs_t cs,
    input  logic [7:0]           latch0,
    input  logic [7:0]           latch1,
    input  logic [7:0]           fm_dout,
    input  logic [7:0]           pcm_dout,
    input  logic [7:0]           ram_q,
    input  logic [7:0]           rom_data,
    input  logic                 rom_ok,
    output logic [7:0]           din,
    output logic                 rom_ready
);

    logic [7:0] cmd_latch, dev_latch, mem_latch;  // stage 1 data
    logic       cmd_hit, dev_hit, mem_hit;        // stage 1 flags
    logic       rom_ok_d;
    logic       no_sel;

    // stage 1 data, pairs narrowed to one byte each
    always_ff @(posedge clk) begin
        cmd_latch <= cs.latch0 ? latch0 : latch1;
        dev_latch <= cs.fm ? fm_dout : pcm_dout;
        mem_latch <= cs.ram ? ram_q : rom_data;
    end

    // stage 1 flags, stage 2 priority pick
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cmd_hit  <= 1'b0;
            dev_hit  <= 1'b0;
            mem_hit  <= 1'b0;
            rom_ok_d <= 1'b0;
            din      <= snd_bus_pkg::RD_IDLE;
        end else begin
            cmd_hit  <= cs.latch0 | cs.latch1;
            dev_hit  <= cs.fm | cs.pcm;
            mem_hit  <= cs.ram | cs.rom;
            rom_ok_d <= rom_ok;
            if (dev_hit)
                din <= dev_latch;
            else if (cmd_hit)
                din <= cmd_latch;
            else if (mem_hit)
                din <= mem_latch;
            else
                din <= snd_bus_pkg::RD_IDLE;
        end
    end

    // ok held for two clocks, so the SDRAM data has settled
    assign rom_ready = rom_ok & rom_ok_d;

    assign no_sel = !(cs.latch0 | cs.latch1 | cs.fm | cs.pcm | cs.ram | cs.rom);

    // nothing selected two clocks back reads as idle
    a_idle_read: assert property (
        @(posedge clk) disable iff (rst) $past(no_sel, 2) |-> din == snd_bus_pkg::RD_IDLE
    ) else $error("snd_rd_mux: unmapped read did not return idle value");

endmodule

// ==== snd_work_ram.sv ====
`timescale 1ns/1ps

module snd_work_ram #(
    parameter int RAM_AW = 11
) (
    input  logic              clk,
    input  logic [RAM_AW-1:0] addr,
    input  logic [7:0]        din,
    input  logic              we,
    output logic [7:0]        q
);

    localparam int DEPTH = 2 ** RAM_AW;

    logic [7:0] mem [DEPTH];

    // single port, read data registered one clock after addr
    // a write returns the old byte on the same clock
    always_ff @(posedge clk) begin
        if (we)
            mem[addr] <= din;
        q <= mem[addr];
    end

endmodule

// ==== tb_snd_board.sv ====
`timescale 1ns/1ps

module tb_snd_board;

    localparam logic [9:0] CEN_N = 10'd1;
    localparam logic [9:0] CEN_M = 10'd8;

    localparam int NUM_STEPS   = 22;
    localparam int HOLD_CLKS   = 5;    // clocks per bus access
    localparam int N_MIX       = 24;   // samples per enable combination
    localparam int CEN_CLKS    = 800;
    // write cycles may stretch while waiting for cpu_cen
    localparam int CYCLE_LIMIT = NUM_STEPS * 16 + 4 * N_MIX + CEN_CLKS + 500;

    localparam logic [1:0] OP_ROM = 2'd0;  // read, exp is the ROM address
    localparam logic [1:0] OP_RD  = 2'd1;  // read, exp is din
    localparam logic [1:0] OP_WR  = 2'd2;  // write, exp is {fm_wr, pcm_wr, rate}

    typedef struct packed {
        logic [1:0]  op;
        logic [15:0] addr;
        logic [7:0]  data;
        logic [15:0] exp;
    } step_t;

    logic                      clk;
    logic                      rst;
    snd_bus_pkg::snd_cpu_bus_t bus;
    logic [7:0]                din;
    logic                      cpu_cen;
    logic [7:0]                snd_latch0, snd_latch1;
    logic                      fm_en, pcm_en;
    logic [15:0]               rom_addr;
    logic                      rom_cs, rom_ok, rom_ready;
    logic [7:0]                rom_data;
    logic                      fm_wr, fm_a0, pcm_wr, pcm_rate_sel;
    logic [7:0]                fm_dout, pcm_dout;
    snd_audio_pkg::sample_t    fm_left, fm_right, pcm_snd, left, right;

    step_t       steps [NUM_STEPS];
    int          errors;
    int          checks;
    int          cycles = 0;
    integer      seed;
    logic [15:0] cap_rom_addr;   // values seen during the last bus access
    logic        cap_rom_cs, cap_rom_ready, cap_fm_wr, cap_fm_a0, cap_pcm_wr;
    logic [7:0]  cap_din;

    snd_board #(
        .CEN_N  (CEN_N),
        .CEN_M  (CEN_M),
        .RAM_AW (11)
    ) i_snd_board (
        .clk (clk), .rst (rst), .bus (bus), .din (din), .cpu_cen (cpu_cen),
        .snd_latch0 (snd_latch0), .snd_latch1 (snd_latch1),
        .fm_en (fm_en), .pcm_en (pcm_en),
        .rom_addr (rom_addr), .rom_cs (rom_cs), .rom_data (rom_data),
        .rom_ok (rom_ok), .rom_ready (rom_ready),
        .fm_wr (fm_wr), .fm_a0 (fm_a0), .fm_dout (fm_dout),
        .pcm_wr (pcm_wr), .pcm_rate_sel (pcm_rate_sel), .pcm_dout (pcm_dout),
        .fm_left (fm_left), .fm_right (fm_right), .pcm_snd (pcm_snd),
        .left (left), .right (right)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: test still running after %0d clocks", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    // model ROM byte, depends on every address bit
    function automatic logic [7:0] rom_byte(input logic [15:0] a);
        return a[15:8] ^ a[7:0] ^ 8'h5a;
    endfunction

    always @(posedge clk) begin
        #1;
        rom_data = rom_byte(rom_addr);  // ROM answers the registered address
    end

    // weighted sum of two channels, 4.4 gains, clipped to 16 bits
    function automatic logic [15:0] mix_model(input int fm, input int pcm,
                                              input logic fm_on, input logic pcm_on);
        int s;
        s = (fm_on ? fm * 8 : 0) + (pcm_on ? pcm * 16 : 0);
        s = s >>> 4;
        if (s > 32767)
            s = 32767;
        else if (s < -32768)
            s = -32768;
        return s[15:0];
    endfunction

    task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s, got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic read_cycle(input logic [15:0] addr);
        int n;
        bus      = '0;
        bus.addr = addr;
        bus.mreq = 1'b1;
        bus.rd   = 1'b1;
        for (n = 1; n <= HOLD_CLKS; n++) begin
            @(posedge clk);
            #1;
            if (n == 1) begin
                cap_rom_addr = rom_addr;
                cap_rom_cs   = rom_cs;
            end
            if (n == 3) begin  // decode, stage 1, stage 2
                cap_din       = din;
                cap_rom_ready = rom_ready;
            end
        end
        bus = '0;
        @(posedge clk);  // lets the selects drop before the next access
        #1;
    endtask

    task automatic write_cycle(input logic [15:0] addr, input logic [7:0] data);
        int   n;
        logic armed;
        logic landed;
        n        = 0;
        armed    = 1'b0;
        landed   = 1'b0;
        bus      = '0;
        bus.addr = addr;
        bus.mreq = 1'b1;
        bus.wr   = 1'b1;
        bus.dout = data;
        while (n < HOLD_CLKS || !landed) begin
            @(posedge clk);
            #1;
            n++;
            if (armed)
                landed = 1'b1;
            if (cpu_cen)
                armed = 1'b1;   // enable is high on the coming edge
            if (n == 1) begin
                cap_fm_wr  = fm_wr;
                cap_fm_a0  = fm_a0;
                cap_pcm_wr = pcm_wr;
            end
        end
        bus = '0;
        @(posedge clk);
        #1;
    endtask

    task automatic load_steps();
        steps[0]  = '{OP_ROM, 16'h1234, 8'h00, 16'h1234};  // fixed ROM
        steps[1]  = '{OP_ROM, 16'h5678, 8'h00, 16'h5678};
        steps[2]  = '{OP_WR,  16'hf004, 8'h01, 16'h0000};  // bank 1
        steps[3]  = '{OP_ROM, 16'h9234, 8'h00, 16'hd234};
        steps[4]  = '{OP_WR,  16'hf004, 8'h00, 16'h0000};  // bank 0
        steps[5]  = '{OP_ROM, 16'h9234, 8'h00, 16'h9234};
        steps[6]  = '{OP_WR,  16'hd000, 8'h5a, 16'h0000};
        steps[7]  = '{OP_WR,  16'hd123, 8'ha5, 16'h0000};
        steps[8]  = '{OP_WR,  16'hd7ff, 8'h96, 16'h0000};
        steps[9]  = '{OP_RD,  16'hd000, 8'h00, 16'h005a};
        steps[10] = '{OP_RD,  16'hd123, 8'h00, 16'h00a5};
        steps[11] = '{OP_RD,  16'hd7ff, 8'h00, 16'h0096};
        steps[12] = '{OP_RD,  16'hf008, 8'h00, 16'h0071};  // latch0
        steps[13] = '{OP_RD,  16'hf00a, 8'h00, 16'h008e};  // latch1
        steps[14] = '{OP_RD,  16'hf000, 8'h00, 16'h0081};  // FM status
        steps[15] = '{OP_RD,  16'hf002, 8'h00, 16'h0042};  // PCM status
        steps[16] = '{OP_RD,  16'he000, 8'h00, 16'h00ff};  // unmapped
        steps[17] = '{OP_WR,  16'hf000, 8'h20, 16'h0004};  // FM address port
        steps[18] = '{OP_WR,  16'hf001, 8'h7f, 16'h0004};  // FM data port
        steps[19] = '{OP_WR,  16'hf002, 8'h33, 16'h0002};
        steps[20] = '{OP_WR,  16'hf006, 8'h01, 16'h0001};  // rate select on
        steps[21] = '{OP_WR,  16'hf006, 8'h00, 16'h0000};
    endtask

    initial begin
        int          i, k, combo, cen_count;
        step_t       s;
        logic [15:0] exp_l, exp_r;
        errors     = 0;
        checks     = 0;
        seed       = 45015;
        rst        = 1'b1;
        bus        = '0;
        snd_latch0 = 8'h71;
        snd_latch1 = 8'h8e;
        fm_dout    = 8'h81;
        pcm_dout   = 8'h42;
        fm_en      = 1'b0;
        pcm_en     = 1'b0;
        rom_ok     = 1'b0;
        rom_data   = 8'h00;
        fm_left    = '0;
        fm_right   = '0;
        pcm_snd    = '0;
        load_steps();
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        check_equal(rom_cs, 1'b0, "rom_cs after reset");
        check_equal(fm_wr, 1'b0, "fm_wr after reset");
        check_equal(pcm_wr, 1'b0, "pcm_wr after reset");
        check_equal(pcm_rate_sel, 1'b0, "pcm_rate_sel after reset");
        check_equal(din, 8'hff, "din after reset");
        check_equal({16'h0, left}, 32'h0, "left after reset");
        check_equal({16'h0, right}, 32'h0, "right after reset");
        check_equal(rom_ready, 1'b0, "rom_ready with rom_ok low");
        rom_ok = 1'b1;
        #1;
        check_equal(rom_ready, 1'b0, "rom_ready on the first clock of rom_ok");
        @(posedge clk);
        #1;
        check_equal(rom_ready, 1'b1, "rom_ready after two clocks of rom_ok");

        for (i = 0; i < NUM_STEPS; i++) begin
            s = steps[i];
            case (s.op)
                OP_ROM: begin
                    read_cycle(s.addr);
                    check_equal(cap_rom_addr, s.exp, "rom_addr");
                    check_equal(cap_rom_cs, 1'b1, "rom_cs");
                    check_equal(cap_din, rom_byte(s.exp), "ROM byte on din");
                    check_equal(cap_rom_ready, 1'b1, "rom_ready");
                end
                OP_RD: begin
                    read_cycle(s.addr);
                    check_equal(cap_din, s.exp[7:0], "din");
                end
                default: begin
                    write_cycle(s.addr, s.data);
                    check_equal(cap_fm_wr, s.exp[2], "fm_wr");
                    check_equal(cap_fm_a0, s.addr[0], "fm_a0");
                    check_equal(cap_pcm_wr, s.exp[1], "pcm_wr");
                    check_equal(pcm_rate_sel, s.exp[0], "pcm_rate_sel");
                end
            endcase
        end

        // all four enable combinations, extremes first
        for (combo = 0; combo < 4; combo++) begin
            fm_en  = combo[0];
            pcm_en = combo[1];
            for (k = 0; k < N_MIX; k++) begin
                case (k)
                    0: begin
                        fm_left = 16'sh7fff;
                        pcm_snd = 16'sh7fff;
                    end
                    1: begin
                        fm_left = 16'sh8000;
                        pcm_snd = 16'sh8000;
                    end
                    2: begin
                        fm_left = 16'sh7fff;
                        pcm_snd = 16'sh8000;
                    end
                    3: begin
                        fm_left = 16'sh0000;
                        pcm_snd = 16'sh8000;
                    end
                    default: begin
                        fm_left = 16'($random(seed));
                        pcm_snd = 16'($random(seed));
                    end
                endcase
                fm_right = ~fm_left;
                exp_l = mix_model(fm_left, pcm_snd, fm_en, pcm_en);
                exp_r = mix_model(fm_right, pcm_snd, fm_en, pcm_en);
                @(posedge clk);
                #1;
                check_equal({16'h0, left}, {16'h0, exp_l}, "left mix");
                check_equal({16'h0, right}, {16'h0, exp_r}, "right mix");
            end
        end

        cen_count = 0;
        repeat (CEN_CLKS) begin
            @(posedge clk);
            #1;
            if (cpu_cen)
                cen_count++;
        end
        check_equal(cen_count, CEN_N * (CEN_CLKS / CEN_M), "cpu_cen pulse count");

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
